// ==== Makefile ====
SRCS := $(shell grep -v '^+' tb.f)

obj_dir/VtomasuloTb: tb.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps -f tb.f \
		--top-module tomasuloTb -o VtomasuloTb

run: obj_dir/VtomasuloTb
	./obj_dir/VtomasuloTb | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== common/tomasuloPkg.sv ====
`default_nettype none

package tomasuloPkg;

    localparam int dataWidth       = 32;
    localparam int numRegs         = 8;
    localparam int slotsPerStation = 3;

    typedef logic [2:0] regIdx_t;

    // {station id, slot}, zero means the value is present
    typedef logic [3:0] tag_t;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        LDI
    } opcode_t;

    typedef struct packed {
        opcode_t              op;
        regIdx_t              dst;
        regIdx_t              src1;
        regIdx_t              src2;
        logic [dataWidth-1:0] imm;   // LDI only
    } issueInst_t;

    typedef struct packed {
        opcode_t              op;
        tag_t                 qj;
        logic [dataWidth-1:0] vj;
        tag_t                 qk;
        logic [dataWidth-1:0] vk;
    } rsEntry_t;

    typedef struct packed {
        opcode_t              op;
        logic [dataWidth-1:0] a;
        logic [dataWidth-1:0] b;
        tag_t                 tag;
    } execReq_t;

    typedef struct packed {
        logic                 valid;
        tag_t                 tag;
        logic [dataWidth-1:0] data;
    } cdb_t;

endpackage

`default_nettype wire

// ==== resStation/reservationStation.sv ====
`default_nettype none

module reservationStation import tomasuloPkg::*; #(
    parameter logic [1:0] stationId = 2'd1
) (
    input  logic     clk,
    input  logic     nRST,
    input  logic     write,
    input  rsEntry_t entry,
    input  cdb_t     cdb,
    input  logic     idle,
    output logic     full,
    output tag_t     freeTag,
    output logic     dispatch,
    output execReq_t req
);

    typedef logic [1:0] slotIdx_t;

    logic [slotsPerStation-1:0] busy;   // slot holds a waiting entry
    logic [slotsPerStation-1:0] held;   // dispatched, tag still in flight
    rsEntry_t                   slot [slotsPerStation];

    slotIdx_t freeIdx;
    slotIdx_t readyIdx;
    logic     anyFree;
    logic     anyReady;

    function automatic tag_t slotTag(input slotIdx_t idx);
        return {stationId, idx};
    endfunction

    // priority encoders, lowest index wins
    always_comb begin
        freeIdx  = '0;
        readyIdx = '0;
        anyFree  = 1'b0;
        anyReady = 1'b0;
        for (int i = slotsPerStation - 1; i >= 0; i--) begin
            if (!busy[i] && !held[i]) begin
                freeIdx = slotIdx_t'(i);
                anyFree = 1'b1;
            end
            if (busy[i] && slot[i].qj == '0 && slot[i].qk == '0) begin
                readyIdx = slotIdx_t'(i);
                anyReady = 1'b1;
            end
        end
    end

    assign full     = !anyFree;
    assign freeTag  = slotTag(freeIdx);
    assign dispatch = anyReady && idle;

    always_comb begin
        req.op  = slot[readyIdx].op;
        req.a   = slot[readyIdx].vj;
        req.b   = slot[readyIdx].vk;
        req.tag = slotTag(readyIdx);
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy <= '0;
            held <= '0;
        end else begin
            // tag becomes reusable once its result is on the bus
            for (int i = 0; i < slotsPerStation; i++) begin
                if (held[i] && cdb.valid && cdb.tag == slotTag(slotIdx_t'(i))) begin
                    held[i] <= 1'b0;
                end
            end
            if (dispatch) begin
                busy[readyIdx] <= 1'b0;
                held[readyIdx] <= 1'b1;
            end
            if (write && anyFree) begin
                busy[freeIdx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < slotsPerStation; i++) begin
            if (busy[i] && cdb.valid) begin
                if (slot[i].qj == cdb.tag) begin
                    slot[i].qj <= '0;
                    slot[i].vj <= cdb.data;
                end
                if (slot[i].qk == cdb.tag) begin
                    slot[i].qk <= '0;
                    slot[i].vk <= cdb.data;
                end
            end
        end
        if (write && anyFree) begin
            slot[freeIdx] <= entry;   // operands already bypassed by issue
        end
    end

    // issue must honour full
    assert property (@(posedge clk) disable iff (!nRST) write |-> !full)
        else $error("station %0d written while full", stationId);

    // a broadcast leaves no busy slot waiting on its tag
    for (genvar g = 0; g < slotsPerStation; g++) begin : gSnoop
        assert property (@(posedge clk) disable iff (!nRST)
            cdb.valid |=> !(busy[g] && (slot[g].qj == $past(cdb.tag)
                                        || slot[g].qk == $past(cdb.tag))))
            else $error("station %0d slot %0d missed a broadcast", stationId, g);
    end

endmodule

`default_nettype wire

// ==== rtl/cdbArbiter.sv ====
`default_nettype none

module cdbArbiter import tomasuloPkg::*; (
    input  logic                 clk,
    input  logic                 nRST,
    input  logic                 req0,
    input  logic                 req1,
    input  tag_t                 tag0,
    input  tag_t                 tag1,
    input  logic [dataWidth-1:0] data0,
    input  logic [dataWidth-1:0] data1,
    output logic                 grant0,
    output logic                 grant1,
    output cdb_t                 cdb
);

    logic lastWin1;   // requester 1 had the last grant

    // on a conflict the other side goes first
    assign grant0 = req0 && (!req1 || lastWin1);
    assign grant1 = req1 && (!req0 || !lastWin1);

    always_comb begin
        cdb.valid = grant0 || grant1;
        cdb.tag   = grant1 ? tag1 : tag0;
        cdb.data  = grant1 ? data1 : data0;
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            lastWin1 <= 1'b0;
        end else if (grant0 || grant1) begin
            lastWin1 <= grant1;
        end
    end

    // a requester refused now is served on the next cycle
    assert property (@(posedge clk) disable iff (!nRST)
        req0 && !grant0 |=> grant0 || !req0)
        else $error("requester 0 waited more than one cycle for the bus");

    assert property (@(posedge clk) disable iff (!nRST)
        req1 && !grant1 |=> grant1 || !req1)
        else $error("requester 1 waited more than one cycle for the bus");

endmodule

`default_nettype wire

// ==== rtl/execUnit.sv ====
`default_nettype none

module execUnit import tomasuloPkg::*; #(
    parameter int latency = 1
) (
    input  logic                 clk,
    input  logic                 nRST,
    input  logic                 dispatch,
    input  execReq_t             req,
    input  logic                 grant,
    output logic                 idle,
    output logic                 resultReq,
    output tag_t                 resultTag,
    output logic [dataWidth-1:0] resultData
);

    localparam int cntW = (latency > 1) ? $clog2(latency) : 1;

    logic            busy;
    logic [cntW-1:0] count;    // edges left before the result is posted
    logic            finish;
    execReq_t        held;

    function automatic logic [dataWidth-1:0] alu(input execReq_t r);
        case (r.op)
            ADD:     return r.a + r.b;
            SUB:     return r.a - r.b;
            AND:     return r.a & r.b;
            OR:      return r.a | r.b;
            XOR:     return r.a ^ r.b;
            default: return '0;
        endcase
    endfunction

    assign idle      = !busy;
    assign finish    = busy && !resultReq && count == '0;
    assign resultTag = held.tag;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy      <= 1'b0;
            resultReq <= 1'b0;
            count     <= '0;
        end else begin
            if (dispatch) begin
                busy  <= 1'b1;
                count <= cntW'(latency - 1);
            end else if (resultReq) begin
                if (grant) begin   // result leaves on the bus
                    busy      <= 1'b0;
                    resultReq <= 1'b0;
                end
            end else if (busy) begin
                if (count == '0) begin
                    resultReq <= 1'b1;
                end else begin
                    count <= count - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch) begin
            held <= req;
        end
        if (finish) begin
            resultData <= alu(held);
        end
    end

    assert property (@(posedge clk) disable iff (!nRST)
        resultReq && !grant |=> resultReq && $stable(resultTag) && $stable(resultData))
        else $error("result changed while waiting for the bus");

endmodule

`default_nettype wire

// ==== rtl/issueUnit.sv ====
`default_nettype none

module issueUnit import tomasuloPkg::*; (
    input  logic                 clk,
    input  logic                 nRST,
    input  logic                 issueValid,
    input  issueInst_t           issueInst,
    input  logic                 full1,
    input  logic                 full2,
    input  tag_t                 freeTag1,
    input  tag_t                 freeTag2,
    input  cdb_t                 cdb,
    input  regIdx_t              regAddr,
    output logic                 issueStall,
    output logic                 rsWrite1,
    output logic                 rsWrite2,
    output rsEntry_t             rsEntry,
    output logic [dataWidth-1:0] regData
);

    logic [dataWidth-1:0] regVal [numRegs];
    tag_t                 regTag [numRegs];   // producer of the pending value

    logic toArith;
    logic toLogic;
    logic isLdi;
    logic take;
    tag_t dstTag;

    assign toArith    = issueInst.op inside {ADD, SUB};
    assign toLogic    = issueInst.op inside {AND, OR, XOR};
    assign isLdi      = issueInst.op == LDI;
    assign issueStall = (toArith && full1) || (toLogic && full2);   // LDI never waits
    assign take       = issueValid && !issueStall;
    assign rsWrite1   = take && toArith;
    assign rsWrite2   = take && toLogic;
    assign dstTag     = toArith ? freeTag1 : freeTag2;
    assign regData    = regVal[regAddr];

    // operand read with bypass of this cycle's broadcast
    always_comb begin
        rsEntry.op = issueInst.op;
        rsEntry.qj = regTag[issueInst.src1];
        rsEntry.vj = regVal[issueInst.src1];
        rsEntry.qk = regTag[issueInst.src2];
        rsEntry.vk = regVal[issueInst.src2];
        if (cdb.valid && rsEntry.qj == cdb.tag) begin
            rsEntry.qj = '0;
            rsEntry.vj = cdb.data;
        end
        if (cdb.valid && rsEntry.qk == cdb.tag) begin
            rsEntry.qk = '0;
            rsEntry.vk = cdb.data;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < numRegs; i++) begin
                regVal[i] <= '0;
                regTag[i] <= '0;
            end
        end else begin
            // only the latest producer of a register may retire into it
            for (int i = 0; i < numRegs; i++) begin
                if (cdb.valid && regTag[i] == cdb.tag) begin
                    regVal[i] <= cdb.data;
                    regTag[i] <= '0;
                end
            end
            if (take) begin   // new rename overrides the retirement above
                if (isLdi) begin
                    regVal[issueInst.dst] <= issueInst.imm;
                    regTag[issueInst.dst] <= '0;
                end else begin
                    regTag[issueInst.dst] <= dstTag;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/tomasuloCore.sv ====
`default_nettype none

module tomasuloCore import tomasuloPkg::*; #(
    parameter int arithLatency = 1,
    parameter int logicLatency = 2
) (
    input  logic                 clk,
    input  logic                 nRST,
    input  logic                 issueValid,
    input  issueInst_t           issueInst,
    output logic                 issueStall,
    output cdb_t                 cdb,
    input  regIdx_t              regAddr,
    output logic [dataWidth-1:0] regData
);

    logic                 rsWrite1;
    logic                 rsWrite2;
    rsEntry_t             rsEntry;
    logic                 full1;
    logic                 full2;
    tag_t                 freeTag1;
    tag_t                 freeTag2;
    logic                 dispatch1;
    logic                 dispatch2;
    execReq_t             req1;
    execReq_t             req2;
    logic                 idle1;
    logic                 idle2;
    logic                 resultReq1;
    logic                 resultReq2;
    tag_t                 resultTag1;
    tag_t                 resultTag2;
    logic [dataWidth-1:0] resultData1;
    logic [dataWidth-1:0] resultData2;
    logic                 grant1;
    logic                 grant2;

    issueUnit issue (
        .clk, .nRST, .issueValid, .issueInst,
        .full1, .full2, .freeTag1, .freeTag2,
        .cdb, .regAddr,
        .issueStall, .rsWrite1, .rsWrite2, .rsEntry, .regData
    );

    // arithmetic side, ADD and SUB
    reservationStation #(.stationId(2'd1)) station1 (
        .clk, .nRST, .write(rsWrite1), .entry(rsEntry), .cdb, .idle(idle1),
        .full(full1), .freeTag(freeTag1), .dispatch(dispatch1), .req(req1)
    );

    execUnit #(.latency(arithLatency)) unit1 (
        .clk, .nRST, .dispatch(dispatch1), .req(req1), .grant(grant1),
        .idle(idle1), .resultReq(resultReq1), .resultTag(resultTag1),
        .resultData(resultData1)
    );

    // logic side, AND OR XOR
    reservationStation #(.stationId(2'd2)) station2 (
        .clk, .nRST, .write(rsWrite2), .entry(rsEntry), .cdb, .idle(idle2),
        .full(full2), .freeTag(freeTag2), .dispatch(dispatch2), .req(req2)
    );

    execUnit #(.latency(logicLatency)) unit2 (
        .clk, .nRST, .dispatch(dispatch2), .req(req2), .grant(grant2),
        .idle(idle2), .resultReq(resultReq2), .resultTag(resultTag2),
        .resultData(resultData2)
    );

    cdbArbiter arbiter (
        .clk, .nRST,
        .req0(resultReq1), .req1(resultReq2),
        .tag0(resultTag1), .tag1(resultTag2),
        .data0(resultData1), .data1(resultData2),
        .grant0(grant1), .grant1(grant2),
        .cdb
    );

endmodule

`default_nettype wire

// ==== tb.f ====
common/tomasuloPkg.sv
resStation/reservationStation.sv
rtl/execUnit.sv
rtl/cdbArbiter.sv
rtl/issueUnit.sv
rtl/tomasuloCore.sv
verif/tomasuloTb.sv

// ==== verif/tomasuloTb.sv ====
`default_nettype none

module tomasuloTb import tomasuloPkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    // six tests of at most a few hundred cycles each, with a wide margin
    localparam int maxCycles = 3000;

    logic                 clk;
    logic                 nRST;
    logic                 issueValid;
    issueInst_t           issueInst;
    logic                 issueStall;
    cdb_t                 cdb;
    regIdx_t              regAddr;
    logic [dataWidth-1:0] regData;

    logic [dataWidth-1:0] model [numRegs];   // register state in program order
    logic [31:0]          rng;
    bit                   inFlight [16];     // tags issued but not yet broadcast
    logic [dataWidth-1:0] tagResult [16];    // expected data of each tag in flight
    int                   errors;
    int                   cycles;
    int                   busCount;
    int                   nonLdiCount;
    int                   stallCycles;

    tomasuloCore #(.arithLatency(1), .logicLatency(2)) UUT (
        .clk, .nRST, .issueValid, .issueInst, .issueStall, .cdb, .regAddr, .regData
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= maxCycles) begin
            $display("timeout: the run did not finish within %0d cycles", maxCycles);
            $display("Some tests failed");
            $finish;
        end
    end

    // bus monitor, every broadcast must retire a tag in flight
    always @(negedge clk) begin
        if (nRST && cdb.valid) begin
            busCount++;
            if (!inFlight[cdb.tag]) begin
                reportFailure($sformatf("CDB broadcast of tag %h which is not in flight",
                                        cdb.tag));
            end else begin
                checkVal("cdb.data", cdb.data, tagResult[cdb.tag]);
            end
            inFlight[cdb.tag] = 1'b0;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] applyOp(input opcode_t op, input logic [31:0] a,
                                            input logic [31:0] b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            default: return '0;
        endcase
    endfunction

    function automatic issueInst_t makeInst(input opcode_t op, input int dst, input int src1,
                                            input int src2, input logic [31:0] imm);
        issueInst_t inst;
        inst.op   = op;
        inst.dst  = regIdx_t'(dst);
        inst.src1 = regIdx_t'(src1);
        inst.src2 = regIdx_t'(src2);
        inst.imm  = imm;
        return inst;
    endfunction

    task automatic checkVal(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, expected);
        end
    endtask

    task automatic reportFailure(input string msg);
        errors++;
        $display("%0t ns: %s", $time, msg);
    endtask

    // holds the strobe until the DUT takes the instruction
    task automatic issue(input issueInst_t inst);
        tag_t tag;
        issueInst  = inst;
        issueValid = 1'b1;
        @(negedge clk);
        while (issueStall) begin
            stallCycles++;
            @(negedge clk);
        end
        if (inst.op == LDI) begin
            model[inst.dst] = inst.imm;
        end else begin
            model[inst.dst] = applyOp(inst.op, model[inst.src1], model[inst.src2]);
            tag = (inst.op inside {ADD, SUB}) ? UUT.freeTag1 : UUT.freeTag2;
            checkVal("issue tag station", 32'(tag[3:2]),
                     (inst.op inside {ADD, SUB}) ? 32'd1 : 32'd2);
            if (int'(tag[1:0]) >= slotsPerStation) begin
                reportFailure($sformatf("issue tag %h names a slot that does not exist", tag));
            end
            if (inFlight[tag]) begin
                reportFailure($sformatf("tag %h issued again while still in flight", tag));
            end
            inFlight[tag]  = 1'b1;
            tagResult[tag] = model[inst.dst];
            nonLdiCount++;
        end
        @(posedge clk);
        #2;
        issueValid = 1'b0;
    endtask

    // strobe stays low so nothing is taken
    task automatic probeStall(input issueInst_t inst, input logic expected);
        issueInst = inst;
        @(negedge clk);
        checkVal("issueStall", 32'(issueStall), 32'(expected));
        @(posedge clk);
        #2;
    endtask

    task automatic drain();
        int quiet;
        quiet = 0;
        while (quiet < 10) begin
            @(negedge clk);
            if (cdb.valid) begin
                quiet = 0;
            end else begin
                quiet++;
            end
        end
        @(posedge clk);
        #2;
    endtask

    task automatic checkRegs();
        for (int i = 0; i < numRegs; i++) begin
            regAddr = regIdx_t'(i);
            @(negedge clk);
            checkVal($sformatf("regData[r%0d]", i), regData, model[i]);
            @(posedge clk);
            #2;
        end
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        if (errors == errorsBefore) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errorsBefore);
        end
    endtask

    initial begin
        int mark;
        int busBefore;
        int issuedBefore;
        int stallBefore;
        nRST        = 1'b0;
        issueValid  = 1'b0;
        issueInst   = '0;
        regAddr     = '0;
        rng         = 32'h983b_5755;
        errors      = 0;
        cycles      = 0;
        busCount    = 0;
        nonLdiCount = 0;
        stallCycles = 0;
        for (int i = 0; i < numRegs; i++) begin
            model[i] = '0;
        end
        repeat (10) @(posedge clk);
        #2;
        nRST = 1'b1;

        mark = errors;
        checkVal("cdb.valid", 32'(cdb.valid), 32'd0);
        checkVal("issueStall", 32'(issueStall), 32'd0);
        checkRegs();
        for (int i = 0; i < numRegs; i++) begin
            rng = xorshift(rng);
            issue(makeInst(LDI, i, 0, 0, {rng[31:4], 4'(i)}));   // low nibble keeps them apart
        end
        checkRegs();
        reportTest("1 ldi and reset", mark);

        mark = errors;
        issue(makeInst(ADD, 0, 1, 2, '0));
        issue(makeInst(SUB, 3, 4, 5, '0));
        issue(makeInst(AND, 6, 7, 1, '0));
        issue(makeInst(OR, 2, 4, 7, '0));
        issue(makeInst(XOR, 5, 1, 4, '0));
        drain();
        checkRegs();
        reportTest("2 independent ops", mark);

        mark = errors;
        issue(makeInst(ADD, 1, 2, 3, '0));
        issue(makeInst(AND, 4, 1, 5, '0));
        issue(makeInst(SUB, 1, 4, 2, '0));   // WAW on r1
        drain();
        checkRegs();
        reportTest("3 dependency chain", mark);

        mark = errors;
        issue(makeInst(XOR, 3, 1, 2, '0));   // slow head of the chain
        issue(makeInst(AND, 3, 3, 1, '0));
        for (int i = 0; i < slotsPerStation; i++) begin
            issue(makeInst(ADD, 3, 3, 2, '0));
        end
        probeStall(makeInst(ADD, 3, 3, 2, '0), 1'b1);
        probeStall(makeInst(LDI, 7, 0, 0, '0), 1'b0);
        stallBefore = stallCycles;
        rng = xorshift(rng);
        issue(makeInst(LDI, 7, 0, 0, rng));
        checkVal("LDI stall cycles", 32'(stallCycles - stallBefore), 32'd0);
        issue(makeInst(SUB, 4, 3, 1, '0));
        issue(makeInst(ADD, 3, 4, 7, '0));
        issue(makeInst(SUB, 5, 3, 4, '0));
        if (stallCycles == stallBefore) begin
            reportFailure("issue never stalled on the full arithmetic station");
        end
        drain();
        checkRegs();
        reportTest("4 stall and recovery", mark);

        mark = errors;
        busBefore    = busCount;
        issuedBefore = nonLdiCount;
        for (int i = 0; i < 12; i++) begin
            if (i % 2 == 0) begin
                issue(makeInst((i % 4 == 0) ? ADD : SUB, i % 8, (i + 3) % 8, (i + 5) % 8, '0));
            end else begin
                issue(makeInst((i % 4 == 1) ? OR : XOR, i % 8, (i + 2) % 8, (i + 6) % 8, '0));
            end
        end
        drain();
        checkVal("CDB broadcasts", busCount - busBefore, nonLdiCount - issuedBefore);
        for (int t = 0; t < 16; t++) begin
            if (inFlight[t]) begin
                reportFailure($sformatf("tag %h still in flight after drain", t));
            end
        end
        checkRegs();
        reportTest("5 bus sharing", mark);

        mark = errors;
        for (int i = 0; i < 40; i++) begin
            rng = xorshift(rng);
            issue(makeInst(opcode_t'(rng[2:0] % 3'd6), int'(rng[5:3]), int'(rng[8:6]),
                           int'(rng[11:9]), rng));
        end
        drain();
        checkRegs();
        reportTest("6 random program", mark);

        $display("6 tests run, %0d errors", errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
